/* common/mont_pkg.sv */
package mont_pkg;

    // operand width N and adder limb width used when the top is not overridden
    parameter int default_op_width   = 1024;
    parameter int default_limb_width = 64;

    // controller sequence
    typedef enum logic [2:0] {
        idle,
        load_m,
        load_b,
        add_digit,
        add_quot,
        shift_acc,
        final_sub,
        finish
    } mont_state_t;

    // second adder operand during the main loop
    // encoding keeps b multiples at 1..3 and m multiples at 4..6
    typedef enum logic [2:0] {
        sel_zero,
        sel_b,
        sel_2b,
        sel_3b,
        sel_m,
        sel_2m,
        sel_3m
    } mult_sel_t;

    // add, or subtract through inverted y and carry in
    typedef enum logic {
        op_add,
        op_sub
    } adder_op_t;

endpackage

/* datapath/mp_adder.sv */
module mp_adder #(
    parameter int width      = mont_pkg::default_op_width + 3,
    parameter int limb_width = mont_pkg::default_limb_width
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  mont_pkg::adder_op_t op,
    input  logic [width-1:0]    x,
    input  logic [width-1:0]    y,
    output logic [width-1:0]    sum,
    output logic                negative,
    output logic                done
);

    localparam int num_limbs   = (width + limb_width - 1) / limb_width;
    localparam int padded      = num_limbs * limb_width;
    localparam int count_width = $clog2(num_limbs + 1);

    logic [padded-1:0]      x_reg;
    logic [padded-1:0]      y_reg;
    logic [padded-1:0]      sum_reg;
    logic [limb_width:0]    limb_sum;
    logic                   carry;
    logic [count_width-1:0] limbs_left;
    logic                   running;

    assign running  = (limbs_left != '0);
    assign limb_sum = {1'b0, x_reg[limb_width-1:0]} + {1'b0, y_reg[limb_width-1:0]}
                    + {{limb_width{1'b0}}, carry};
    assign sum      = sum_reg[width-1:0];
    // sign of the difference, meaningful after a subtraction
    assign negative = sum_reg[width-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            carry      <= 1'b0;
            limbs_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // carry in of one completes the two's complement of y
                carry      <= (op == mont_pkg::op_sub);
                limbs_left <= count_width'(num_limbs);
            end else if (running) begin
                carry      <= limb_sum[limb_width];
                limbs_left <= limbs_left - 1'b1;
                done       <= (limbs_left == count_width'(1));
            end
        end
    end

    // operands shift down, finished limbs enter the sum from the top
    always_ff @(posedge clk) begin
        if (start) begin
            x_reg <= padded'(x);
            y_reg <= (op == mont_pkg::op_sub) ? ~padded'(y) : padded'(y);
        end else if (running) begin
            x_reg   <= x_reg >> limb_width;
            y_reg   <= y_reg >> limb_width;
            sum_reg <= {limb_sum[limb_width-1:0], sum_reg[padded-1:limb_width]};
        end
    end

endmodule

/* datapath/operand_store.sv */
module operand_store #(
    parameter int op_width = mont_pkg::default_op_width
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [op_width-1:0]   m,
    input  logic [op_width-1:0]   b,
    input  logic                  load_m,
    input  logic                  load_b,
    input  logic                  store_3x,
    input  logic [op_width+2:0]   sum,
    input  mont_pkg::mult_sel_t   mult_sel,
    output logic [op_width+2:0]   multiple
);

    localparam int ext_width = op_width + 3;

    logic [ext_width-1:0] m_1x;
    logic [ext_width-1:0] m_2x;
    logic [ext_width-1:0] m_3x;
    logic [ext_width-1:0] b_1x;
    logic [ext_width-1:0] b_2x;
    logic [ext_width-1:0] b_3x;
    // which operand the pending 3x sum belongs to
    logic                 target_b;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            target_b <= 1'b0;
        end else if (load_m) begin
            target_b <= 1'b0;
        end else if (load_b) begin
            target_b <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_m) begin
            m_1x <= {3'b000, m};
            m_2x <= {2'b00, m, 1'b0};
        end
        if (load_b) begin
            b_1x <= {3'b000, b};
            b_2x <= {2'b00, b, 1'b0};
        end
        if (store_3x) begin
            if (target_b) begin
                b_3x <= sum;
            end else begin
                m_3x <= sum;
            end
        end
    end

    always_comb begin
        case (mult_sel)
            mont_pkg::sel_b:  multiple = b_1x;
            mont_pkg::sel_2b: multiple = b_2x;
            mont_pkg::sel_3b: multiple = b_3x;
            mont_pkg::sel_m:  multiple = m_1x;
            mont_pkg::sel_2m: multiple = m_2x;
            mont_pkg::sel_3m: multiple = m_3x;
            default:          multiple = '0;
        endcase
    end

endmodule

/* datapath/mont_datapath.sv */
module mont_datapath #(
    parameter int op_width   = mont_pkg::default_op_width,
    parameter int limb_width = mont_pkg::default_limb_width
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic [op_width-1:0] a,
    input  logic [op_width-1:0] b,
    input  logic [op_width-1:0] m,
    input  logic                load_a,
    input  logic                shift_a,
    input  logic                precompute_b,
    input  logic                store_3x,
    input  mont_pkg::mult_sel_t mult_sel,
    input  logic                adder_start,
    input  mont_pkg::adder_op_t adder_op,
    input  logic                acc_clear,
    input  logic                acc_load,
    input  logic                acc_shift,
    input  logic                result_load,
    output logic [1:0]          a_digit,
    output logic [1:0]          acc_low,
    output logic [1:0]          m_low,
    output logic                adder_done,
    output logic                adder_negative,
    output logic [op_width-1:0] result
);

    // three guard bits hold values up to 8m before the shift
    localparam int ext_width = op_width + 3;

    logic [op_width-1:0]  a_reg;
    logic [ext_width-1:0] acc;
    logic [op_width-1:0]  pre_src;
    logic [ext_width-1:0] pre_1x;
    logic [ext_width-1:0] pre_2x;
    logic [ext_width-1:0] multiple;
    logic [ext_width-1:0] adder_x;
    logic [ext_width-1:0] adder_y;
    logic [ext_width-1:0] adder_sum;
    logic                 load_m;
    logic                 load_b;

    // the accumulator is held clear only during precompute
    assign load_m = acc_clear && adder_start && !precompute_b;
    assign load_b = acc_clear && adder_start && precompute_b;

    assign pre_src = precompute_b ? b : m;
    assign pre_1x  = {3'b000, pre_src};
    assign pre_2x  = {2'b00, pre_src, 1'b0};

    assign adder_x = acc_clear ? pre_1x : acc;
    assign adder_y = acc_clear ? pre_2x : multiple;

    assign a_digit = a_reg[1:0];
    assign acc_low = acc[1:0];
    assign m_low   = m[1:0];

    // digit shifter for a, least significant digit first
    always_ff @(posedge clk) begin
        if (load_a) begin
            a_reg <= a;
        end else if (shift_a) begin
            a_reg <= a_reg >> 2;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_clear) begin
            acc <= '0;
        end else if (acc_load) begin
            acc <= adder_sum;
        end else if (acc_shift) begin
            acc <= acc >> 2;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else if (result_load) begin
            result <= acc[op_width-1:0];
        end
    end

    operand_store #(
        .op_width (op_width)
    ) u_store (
        .clk      (clk),
        .resetn   (resetn),
        .m        (m),
        .b        (b),
        .load_m   (load_m),
        .load_b   (load_b),
        .store_3x (store_3x),
        .sum      (adder_sum),
        .mult_sel (mult_sel),
        .multiple (multiple)
    );

    mp_adder #(
        .width      (ext_width),
        .limb_width (limb_width)
    ) u_adder (
        .clk      (clk),
        .resetn   (resetn),
        .start    (adder_start),
        .op       (adder_op),
        .x        (adder_x),
        .y        (adder_y),
        .sum      (adder_sum),
        .negative (adder_negative),
        .done     (adder_done)
    );

endmodule

/* source/mont_control.sv */
module mont_control #(
    parameter int op_width = mont_pkg::default_op_width
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic [1:0]          a_digit,
    input  logic [1:0]          acc_low,
    input  logic [1:0]          m_low,
    input  logic                adder_done,
    input  logic                adder_negative,
    output logic                load_a,
    output logic                shift_a,
    output logic                precompute_b,
    output logic                store_3x,
    output mont_pkg::mult_sel_t mult_sel,
    output logic                adder_start,
    output mont_pkg::adder_op_t adder_op,
    output logic                acc_clear,
    output logic                acc_load,
    output logic                acc_shift,
    output logic                result_load,
    output logic                done
);

    localparam int iter_width = $clog2(op_width / 2);
    localparam logic [iter_width-1:0] last_iter = iter_width'(op_width / 2 - 1);

    mont_pkg::mont_state_t state;
    mont_pkg::mont_state_t next_state;
    mont_pkg::mult_sel_t   digit_sel;
    mont_pkg::mult_sel_t   quot_sel;
    logic [iter_width-1:0] iter;
    logic [1:0]            quot;
    // high while an issued addition is still running
    logic                  busy;

    // m is odd so m*m = 1 mod 4, hence q = -c*m clears the low two bits
    assign quot = 2'd0 - acc_low * m_low;

    always_comb begin
        case (a_digit)
            2'd1:    digit_sel = mont_pkg::sel_b;
            2'd2:    digit_sel = mont_pkg::sel_2b;
            2'd3:    digit_sel = mont_pkg::sel_3b;
            default: digit_sel = mont_pkg::sel_zero;
        endcase
    end

    always_comb begin
        case (quot)
            2'd1:    quot_sel = mont_pkg::sel_m;
            2'd2:    quot_sel = mont_pkg::sel_2m;
            2'd3:    quot_sel = mont_pkg::sel_3m;
            default: quot_sel = mont_pkg::sel_zero;
        endcase
    end

    always_comb begin
        next_state   = state;
        load_a       = 1'b0;
        shift_a      = 1'b0;
        precompute_b = 1'b0;
        store_3x     = 1'b0;
        mult_sel     = mont_pkg::sel_zero;
        adder_start  = 1'b0;
        adder_op     = mont_pkg::op_add;
        acc_clear    = 1'b0;
        acc_load     = 1'b0;
        acc_shift    = 1'b0;
        result_load  = 1'b0;
        case (state)
            mont_pkg::idle: begin
                if (start) begin
                    load_a     = 1'b1;
                    next_state = mont_pkg::load_m;
                end
            end
            // m + 2m, accumulator held at zero
            mont_pkg::load_m: begin
                acc_clear   = 1'b1;
                adder_start = !busy;
                store_3x    = adder_done;
                if (adder_done) begin
                    next_state = mont_pkg::load_b;
                end
            end
            mont_pkg::load_b: begin
                precompute_b = 1'b1;
                acc_clear    = 1'b1;
                adder_start  = !busy;
                store_3x     = adder_done;
                if (adder_done) begin
                    next_state = mont_pkg::add_digit;
                end
            end
            mont_pkg::add_digit: begin
                mult_sel    = digit_sel;
                adder_start = !busy;
                acc_load    = adder_done;
                if (adder_done) begin
                    next_state = mont_pkg::add_quot;
                end
            end
            // acc_low already reflects the digit addition here
            mont_pkg::add_quot: begin
                mult_sel    = quot_sel;
                adder_start = !busy;
                acc_load    = adder_done;
                if (adder_done) begin
                    next_state = mont_pkg::shift_acc;
                end
            end
            mont_pkg::shift_acc: begin
                acc_shift = 1'b1;
                shift_a   = 1'b1;
                if (iter == last_iter) begin
                    next_state = mont_pkg::final_sub;
                end else begin
                    next_state = mont_pkg::add_digit;
                end
            end
            // keep the difference only when c >= m
            mont_pkg::final_sub: begin
                mult_sel    = mont_pkg::sel_m;
                adder_op    = mont_pkg::op_sub;
                adder_start = !busy;
                acc_load    = adder_done && !adder_negative;
                if (adder_done) begin
                    next_state = mont_pkg::finish;
                end
            end
            mont_pkg::finish: begin
                result_load = 1'b1;
                next_state  = mont_pkg::idle;
            end
            default: begin
                next_state = mont_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::idle;
            busy  <= 1'b0;
            iter  <= '0;
            done  <= 1'b0;
        end else begin
            state <= next_state;
            // result register is written in finish, so done trails by one
            done  <= (state == mont_pkg::finish);
            if (adder_start) begin
                busy <= 1'b1;
            end else if (adder_done) begin
                busy <= 1'b0;
            end
            if (state == mont_pkg::idle) begin
                iter <= '0;
            end else if (state == mont_pkg::shift_acc) begin
                iter <= iter + 1'b1;
            end
        end
    end

endmodule

/* source/montgomery.sv */
module montgomery #(
    parameter int op_width   = mont_pkg::default_op_width,
    parameter int limb_width = mont_pkg::default_limb_width
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  logic [op_width-1:0] a,
    input  logic [op_width-1:0] b,
    input  logic [op_width-1:0] m,
    output logic [op_width-1:0] result,
    output logic                done
);

    // controller strobes
    logic                  load_a;
    logic                  shift_a;
    logic                  precompute_b;
    logic                  store_3x;
    mont_pkg::mult_sel_t   mult_sel;
    logic                  adder_start;
    mont_pkg::adder_op_t   adder_op;
    logic                  acc_clear;
    logic                  acc_load;
    logic                  acc_shift;
    logic                  result_load;

    // status back from the datapath
    logic [1:0]            a_digit;
    logic [1:0]            acc_low;
    logic [1:0]            m_low;
    logic                  adder_done;
    logic                  adder_negative;

    mont_control #(
        .op_width (op_width)
    ) u_control (
        .clk            (clk),
        .resetn         (resetn),
        .start          (start),
        .a_digit        (a_digit),
        .acc_low        (acc_low),
        .m_low          (m_low),
        .adder_done     (adder_done),
        .adder_negative (adder_negative),
        .load_a         (load_a),
        .shift_a        (shift_a),
        .precompute_b   (precompute_b),
        .store_3x       (store_3x),
        .mult_sel       (mult_sel),
        .adder_start    (adder_start),
        .adder_op       (adder_op),
        .acc_clear      (acc_clear),
        .acc_load       (acc_load),
        .acc_shift      (acc_shift),
        .result_load    (result_load),
        .done           (done)
    );

    mont_datapath #(
        .op_width   (op_width),
        .limb_width (limb_width)
    ) u_datapath (
        .clk            (clk),
        .resetn         (resetn),
        .a              (a),
        .b              (b),
        .m              (m),
        .load_a         (load_a),
        .shift_a        (shift_a),
        .precompute_b   (precompute_b),
        .store_3x       (store_3x),
        .mult_sel       (mult_sel),
        .adder_start    (adder_start),
        .adder_op       (adder_op),
        .acc_clear      (acc_clear),
        .acc_load       (acc_load),
        .acc_shift      (acc_shift),
        .result_load    (result_load),
        .a_digit        (a_digit),
        .acc_low        (acc_low),
        .m_low          (m_low),
        .adder_done     (adder_done),
        .adder_negative (adder_negative),
        .result         (result)
    );

endmodule

/* bench/mont_ref.svh */
`ifndef mont_ref_svh
`define mont_ref_svh

// bit-serial radix-2 Montgomery product a*b*2^-n mod m
// two spare bits hold c + b + m, which stays below 4m
function automatic logic [op_width-1:0] mont_expected(
    input logic [op_width-1:0] av,
    input logic [op_width-1:0] bv,
    input logic [op_width-1:0] mv
);
    logic [op_width+1:0] c;
    c = '0;
    for (int i = 0; i < op_width; i++) begin
        if (av[i]) begin
            c = c + {2'b00, bv};
        end
        if (c[0]) begin
            c = c + {2'b00, mv};
        end
        c = c >> 1;
    end
    // below 2m here, one subtraction is enough
    if (c >= {2'b00, mv}) begin
        c = c - {2'b00, mv};
    end
    return c[op_width-1:0];
endfunction

// full-width random value built from 32-bit draws
function automatic logic [op_width-1:0] random_word();
    logic [op_width-1:0] w;
    w = '0;
    for (int i = 0; i < op_width; i += 32) begin
        w = (w << 32) | op_width'($urandom);
    end
    return w;
endfunction

// odd modulus with the top bit set
function automatic logic [op_width-1:0] random_modulus();
    logic [op_width-1:0] w;
    w = random_word();
    w[op_width-1] = 1'b1;
    w[0] = 1'b1;
    return w;
endfunction

function automatic logic [op_width-1:0] random_below(input logic [op_width-1:0] modulus);
    return random_word() % modulus;
endfunction

`endif

/* bench/tb_montgomery.sv */
module tb_montgomery;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int op_width      = 64;
    localparam int limb_width    = 16;
    localparam int clk_period    = 100;
    localparam int num_ops       = 25;
    localparam int adder_latency = (op_width + 3 + limb_width - 1) / limb_width + 1;
    localparam int worst_cycles  = (op_width / 2) * (2 * adder_latency + 1)
                                 + 2 * adder_latency;
    localparam longint timeout_ns = longint'(16 + 4 * num_ops * worst_cycles) * clk_period;

    logic                clk;
    logic                resetn;
    logic                start;
    logic [op_width-1:0] a;
    logic [op_width-1:0] b;
    logic [op_width-1:0] m;
    logic [op_width-1:0] result;
    logic                done;

    // expected values of pending operations in issue order
    logic [op_width-1:0] exp_q[$];
    logic [op_width-1:0] mod_q[$];
    string               name_q[$];
    int                  issued;
    int                  checked;
    int                  tests;
    int                  failed_tests;
    int                  errors;

    `include "mont_ref.svh"

    montgomery #(
        .op_width   (op_width),
        .limb_width (limb_width)
    ) dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic log_test(input string name, input bit ok);
        tests++;
        if (!ok) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", tests, name, ok ? "ok" : "failed");
    endtask

    task automatic issue_op(
        input logic [op_width-1:0] av,
        input logic [op_width-1:0] bv,
        input logic [op_width-1:0] mv,
        input string               name
    );
        @(negedge clk);
        a     = av;
        b     = bv;
        m     = mv;
        start = 1'b1;
        exp_q.push_back(mont_expected(av, bv, mv));
        mod_q.push_back(mv);
        name_q.push_back(name);
        issued++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_result();
        wait (checked == issued);
    endtask

    // each done pulse is matched to the oldest pending operation
    initial begin : compare_results
        logic [op_width-1:0] expected;
        logic [op_width-1:0] modulus;
        string               name;
        bit                  ok;
        forever begin
            @(negedge clk);
            if (done) begin
                assert (exp_q.size() != 0) else begin
                    $display("done pulsed at %0t with no start pending", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    modulus  = mod_q.pop_front();
                    name     = name_q.pop_front();
                    ok       = 1'b1;
                    assert (result == expected) else begin
                        $display("mismatch at %0t: result expected %h, actual %h",
                                 $time, expected, result);
                        ok = 1'b0;
                        errors++;
                    end
                    assert (result < modulus) else begin
                        $display("mismatch at %0t: result expected below %h, actual %h",
                                 $time, modulus, result);
                        ok = 1'b0;
                        errors++;
                    end
                    log_test(name, ok);
                    checked++;
                end
            end
        end
    end

    // a stuck controller never leaves the loop states and never returns to idle
    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: done never came within %0d ns", timeout_ns);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        logic [op_width-1:0] m_full;
        logic [op_width-1:0] mv;
        logic [op_width-1:0] av;
        logic [op_width-1:0] bv;
        logic [op_width-1:0] held;
        bit                  ok;
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        void'($urandom(32'ha618));
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        ok = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (done == 1'b0) else begin
                $display("done is high after reset with no start given");
                ok = 1'b0;
                errors++;
            end
            assert (result == '0) else begin
                $display("mismatch at %0t: result expected %h, actual %h",
                         $time, {op_width{1'b0}}, result);
                ok = 1'b0;
                errors++;
            end
        end
        log_test("reset state", ok);

        m_full = '1;
        issue_op('0, random_below(m_full), m_full, "directed a=0");
        wait_result();
        issue_op(op_width'(1), op_width'(1), m_full, "directed a=1 b=1");
        wait_result();
        issue_op(m_full - 1'b1, m_full - 1'b1, m_full, "directed a=b=m-1");
        wait_result();

        repeat (20) begin
            mv = random_modulus();
            av = random_below(mv);
            bv = random_below(mv);
            issue_op(av, bv, mv, "random");
            wait_result();
        end

        // extra start pulses while the first operation runs
        mv = random_modulus();
        av = random_below(mv);
        bv = random_below(mv);
        issue_op(av, bv, mv, "start while busy");
        repeat (3) begin
            repeat (20) @(negedge clk);
            if (checked != issued) begin
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
        end
        wait_result();
        @(negedge clk);
        a = ~av;
        b = ~bv;
        repeat (10) @(negedge clk);

        mv = random_modulus();
        av = random_below(mv);
        bv = random_below(mv);
        issue_op(av, bv, mv, "hold operation");
        wait_result();
        held = mont_expected(av, bv, mv);
        ok   = 1'b1;
        repeat (10) begin
            @(negedge clk);
            a = random_word();
            b = random_word();
            assert (result == held) else begin
                $display("mismatch at %0t: result expected %h, actual %h", $time, held, result);
                ok = 1'b0;
                errors++;
            end
        end
        log_test("result hold", ok);

        repeat (4) @(negedge clk);

        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
common/mont_pkg.sv
datapath/mp_adder.sv
datapath/operand_store.sv
datapath/mont_datapath.sv
source/mont_control.sv
source/montgomery.sv
bench/tb_montgomery.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_montgomery -Mdir obj_dir

output=$(./obj_dir/Vtb_montgomery)
echo "$output"

if echo "$output" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
